//--- Makefile
BUILD = build

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
		--top-module instruction_decoder_tb -Mdir $(BUILD) -o instruction_decoder_tb

run: compile
	@out="$$(./$(BUILD)/instruction_decoder_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)

//--- hw/arm_decode_pkg.sv
package arm_decode_pkg;

    typedef struct packed
    {
        logic n;                            // negative
        logic z;                            // zero
        logic c;                            // carry
        logic v;                            // overflow
    } cpsr_t;

    typedef logic [3:0] reg_idx_t;

    localparam reg_idx_t REG_R0 = 4'd0;
    localparam reg_idx_t REG_LR = 4'd14;
    localparam reg_idx_t REG_PC = 4'd15;

    typedef enum logic [2:0]
    {
        BARREL_LSL = 3'b000,
        BARREL_LSR = 3'b001,
        BARREL_ASR = 3'b010,
        BARREL_ROR = 3'b011,
        BARREL_RRX = 3'b100                 // rotate right through carry
    } barrel_op_e;

    typedef enum logic [3:0]
    {
        ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
        ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
        ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN, // flag-only ops
        ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
    } alu_op_e;

    typedef enum logic [1:0]
    {
        DOUT_HIGH_IMP     = 2'b00,
        DOUT_PASS_THROUGH = 2'b01,
        DOUT_LATCHED      = 2'b10
    } data_out_sel_e;

    typedef enum logic [1:0]
    {
        ADDR_ALU = 2'b00,
        ADDR_PC  = 2'b01,
        ADDR_INC = 2'b10                    // sequential fetch
    } addr_sel_e;

    typedef struct packed
    {
        reg_idx_t read_a_sel;
        reg_idx_t read_b_sel;
        reg_idx_t write_sel;
    } reg_sel_t;

    typedef struct packed
    {
        barrel_op_e  barrel_op;
        alu_op_e     alu_op;
        logic [31:0] shift_val;
        logic [31:0] imm_val;
        logic        read_b_en;
        logic        imm_out_en;            // immediate drives the B bus
    } operand_ctrl_t;

    typedef struct packed
    {
        logic reg_write_en;
        logic pc_write_en;
        logic lr_write_en;
        logic cpsr_write_en;
    } writeback_ctrl_t;

    typedef struct packed
    {
        data_out_sel_e data_out_sel;
        logic          data_out_reg_we;
        logic          mem_write_en;
        logic          addr_update;
        addr_sel_e     addr_sel;
    } memory_ctrl_t;

    typedef struct packed
    {
        reg_sel_t        regs;
        operand_ctrl_t   operand;
        writeback_ctrl_t wb;
        memory_ctrl_t    mem;
    } decode_ctrl_t;

    typedef struct packed
    {
        decode_ctrl_t ctrl;
        reg_idx_t     read_c_sel;           // register file C port, same cycle
    } decode_bundle_t;

    localparam decode_ctrl_t DECODE_DEFAULT = '{
        regs:    '{read_a_sel: REG_R0, read_b_sel: REG_R0, write_sel: REG_R0},
        operand: '{barrel_op: BARREL_LSL, alu_op: ALU_MOV,
                   shift_val: 32'd0, imm_val: 32'd0,
                   read_b_en: 1'b0, imm_out_en: 1'b0},
        wb:      '{reg_write_en: 1'b0, pc_write_en: 1'b0,
                   lr_write_en: 1'b0, cpsr_write_en: 1'b0},
        mem:     '{data_out_sel: DOUT_HIGH_IMP, data_out_reg_we: 1'b0,
                   mem_write_en: 1'b0, addr_update: 1'b0, addr_sel: ADDR_INC}
    };

    localparam logic [31:0] INSTR_NOP = 32'hE1A0_0000;  // MOV R0,R0 with AL

endpackage

//--- hw/branch_decode.sv
`timescale 1ns/1ps

module branch_decode
    import arm_decode_pkg::*;
(
    input  logic [31:0]    instr,
    output decode_bundle_t bundle
);

    logic [31:0] offset;

    // sign-extended word offset; PC already points one instruction ahead
    assign offset = {{6{instr[23]}}, instr[23:0], 2'b00} + 32'd4;

    always_comb
    begin
        bundle = '{ctrl: DECODE_DEFAULT, read_c_sel: REG_R0};

        bundle.ctrl.regs.read_a_sel = REG_PC;
        bundle.ctrl.regs.write_sel  = REG_PC;

        bundle.ctrl.operand.alu_op     = ALU_ADD;           // PC + offset
        bundle.ctrl.operand.barrel_op  = BARREL_LSL;
        bundle.ctrl.operand.imm_val    = offset;
        bundle.ctrl.operand.imm_out_en = 1'b1;

        bundle.ctrl.wb.reg_write_en = 1'b1;
        bundle.ctrl.wb.pc_write_en  = 1'b1;
        bundle.ctrl.wb.lr_write_en  = instr[24];            // L bit, BL saves return

        bundle.ctrl.mem.addr_update = 1'b1;
        bundle.ctrl.mem.addr_sel    = ADDR_ALU;             // next fetch at target
    end

endmodule

//--- hw/cond_check.sv
`timescale 1ns/1ps

module cond_check
    import arm_decode_pkg::*;
(
    input  logic [3:0] cond,
    input  cpsr_t      cpsr,
    output logic       cond_pass
);

    always_comb
    begin
        case (cond)
            4'b0000: cond_pass = cpsr.z;                              // EQ
            4'b0001: cond_pass = !cpsr.z;                             // NE
            4'b0010: cond_pass = cpsr.c;                              // CS/HS
            4'b0011: cond_pass = !cpsr.c;                             // CC/LO
            4'b0100: cond_pass = cpsr.n;                              // MI
            4'b0101: cond_pass = !cpsr.n;                             // PL
            4'b0110: cond_pass = cpsr.v;                              // VS
            4'b0111: cond_pass = !cpsr.v;                             // VC
            4'b1000: cond_pass = cpsr.c && !cpsr.z;                   // HI
            4'b1001: cond_pass = !cpsr.c || cpsr.z;                   // LS
            4'b1010: cond_pass = (cpsr.n == cpsr.v);                  // GE
            4'b1011: cond_pass = (cpsr.n != cpsr.v);                  // LT
            4'b1100: cond_pass = !cpsr.z && (cpsr.n == cpsr.v);       // GT
            4'b1101: cond_pass = cpsr.z || (cpsr.n != cpsr.v);        // LE
            4'b1110: cond_pass = 1'b1;                                // AL
            default: cond_pass = 1'b0;      // 1111 never executes here
        endcase
    end

endmodule

//--- hw/decode_control.sv
`timescale 1ns/1ps

module decode_control
    import arm_decode_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic [31:0]    fd_instruction,
    input  logic           cond_pass,
    output logic [31:0]    instr,
    input  decode_bundle_t dp_bundle,
    input  decode_bundle_t br_bundle,
    input  decode_bundle_t st_bundle,
    output reg_idx_t       reg_read_C_sel,
    output decode_ctrl_t   de_ctrl
);

    logic           is_dp;
    logic           is_branch;
    logic           is_store;
    decode_bundle_t sel_bundle;

    // failed condition executes as a no-op
    assign instr = cond_pass ? fd_instruction : INSTR_NOP;

    assign is_dp     = (instr[27:26] == 2'b00);
    assign is_branch = (instr[27:25] == 3'b101);
    assign is_store  = (instr[27:26] == 2'b01) &&
                       !(instr[25] && instr[4]) &&      // media/undefined space
                       !instr[20];                      // loads not decoded

    always_comb
    begin
        if (is_dp)
        begin
            sel_bundle = dp_bundle;
        end
        else if (is_branch)
        begin
            sel_bundle = br_bundle;
        end
        else if (is_store)
        begin
            sel_bundle = st_bundle;
        end
        else
        begin
            sel_bundle = '{ctrl: DECODE_DEFAULT, read_c_sel: REG_R0};
        end
    end

    assign reg_read_C_sel = sel_bundle.read_c_sel;     // same-cycle register read

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            de_ctrl <= DECODE_DEFAULT;
        end
        else
        begin
            de_ctrl <= sel_bundle.ctrl;
        end
    end

endmodule

//--- hw/dp_decode.sv
`timescale 1ns/1ps

module dp_decode
    import arm_decode_pkg::*;
(
    input  logic [31:0]    instr,
    input  logic [31:0]    reg_read_C_bus,
    output decode_bundle_t bundle
);

    logic     imm_form;
    logic     reg_shift;
    logic     test_op;
    alu_op_e  opcode;
    reg_idx_t rd;

    assign imm_form  = instr[25];
    assign reg_shift = !instr[25] && instr[4];
    assign opcode    = alu_op_e'(instr[24:21]);
    assign rd        = instr[15:12];
    assign test_op   = (opcode == ALU_TST) || (opcode == ALU_TEQ) ||
                       (opcode == ALU_CMP) || (opcode == ALU_CMN);

    always_comb
    begin
        bundle = '{ctrl: DECODE_DEFAULT, read_c_sel: REG_R0};

        bundle.ctrl.regs.read_a_sel = instr[19:16];          // Rn
        bundle.ctrl.regs.write_sel  = rd;
        bundle.ctrl.operand.alu_op  = opcode;

        if (imm_form)
        begin
            // imm8 rotated right by twice the rotate field
            bundle.ctrl.operand.imm_val    = {24'd0, instr[7:0]};
            bundle.ctrl.operand.shift_val  = {27'd0, instr[11:8], 1'b0};
            bundle.ctrl.operand.barrel_op  = BARREL_LSL;
            bundle.ctrl.operand.imm_out_en = 1'b1;
        end
        else if (reg_shift)
        begin
            bundle.ctrl.regs.read_b_sel    = instr[3:0];      // Rm
            bundle.read_c_sel              = instr[11:8];     // Rs
            bundle.ctrl.operand.read_b_en  = 1'b1;
            bundle.ctrl.operand.barrel_op  = barrel_op_e'({1'b0, instr[6:5]});
            bundle.ctrl.operand.shift_val  = reg_read_C_bus;  // amount from Rs
        end
        else
        begin
            bundle.ctrl.regs.read_b_sel    = instr[3:0];      // Rm
            bundle.ctrl.operand.read_b_en  = 1'b1;
            bundle.ctrl.operand.shift_val  = {27'd0, instr[11:7]};
            if (instr[11:7] == 5'd0)
                bundle.ctrl.operand.barrel_op = BARREL_RRX;
            else
                bundle.ctrl.operand.barrel_op = barrel_op_e'({1'b0, instr[6:5]});
        end

        bundle.ctrl.wb.reg_write_en  = !test_op;             // compares only set flags
        bundle.ctrl.wb.cpsr_write_en = instr[20];            // S bit

        if (rd == REG_PC)
        begin
            bundle.ctrl.wb.pc_write_en  = 1'b1;
            bundle.ctrl.mem.addr_update = 1'b1;
            bundle.ctrl.mem.addr_sel    = ADDR_ALU;          // fetch from result
        end
        else
        begin
            bundle.ctrl.mem.addr_sel = ADDR_INC;
        end
    end

endmodule

//--- hw/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder
    import arm_decode_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic [31:0]  fd_instruction,
    input  logic [31:0]  reg_read_C_bus,
    input  cpsr_t        in_cpsr,
    output reg_idx_t     reg_read_C_sel,
    output decode_ctrl_t de_ctrl
);

    logic           cond_pass;
    logic [31:0]    instr;
    decode_bundle_t dp_bundle;
    decode_bundle_t br_bundle;
    decode_bundle_t st_bundle;

    cond_check u_cond_check (
        .cond      (fd_instruction[31:28]),
        .cpsr      (in_cpsr),
        .cond_pass (cond_pass)
    );

    decode_control u_decode_control (
        .clk            (clk),
        .arst_n         (arst_n),
        .fd_instruction (fd_instruction),
        .cond_pass      (cond_pass),
        .instr          (instr),
        .dp_bundle      (dp_bundle),
        .br_bundle      (br_bundle),
        .st_bundle      (st_bundle),
        .reg_read_C_sel (reg_read_C_sel),
        .de_ctrl        (de_ctrl)
    );

    dp_decode u_dp_decode (
        .instr          (instr),
        .reg_read_C_bus (reg_read_C_bus),
        .bundle         (dp_bundle)
    );

    branch_decode u_branch_decode (
        .instr  (instr),
        .bundle (br_bundle)
    );

    store_decode u_store_decode (
        .instr          (instr),
        .reg_read_C_bus (reg_read_C_bus),
        .bundle         (st_bundle)
    );

endmodule

//--- hw/store_decode.sv
`timescale 1ns/1ps

module store_decode
    import arm_decode_pkg::*;
(
    input  logic [31:0]    instr,
    input  logic [31:0]    reg_read_C_bus,
    output decode_bundle_t bundle
);

    logic pre_index;
    logic add_offset;
    logic base_wb;
    logic reg_offset;

    assign pre_index  = instr[24];                          // P
    assign add_offset = instr[23];                          // U
    assign base_wb    = instr[21];                          // W
    assign reg_offset = instr[25];

    always_comb
    begin
        bundle = '{ctrl: DECODE_DEFAULT, read_c_sel: REG_R0};

        bundle.ctrl.regs.read_a_sel = instr[19:16];          // Rn base
        bundle.ctrl.regs.write_sel  = instr[19:16];          // base write-back
        bundle.ctrl.regs.read_b_sel = instr[15:12];          // Rd store data

        bundle.ctrl.operand.alu_op = add_offset ? ALU_ADD : ALU_SUB;

        bundle.ctrl.mem.mem_write_en = 1'b1;
        bundle.ctrl.mem.addr_update  = 1'b1;
        bundle.ctrl.mem.addr_sel     = ADDR_ALU;             // address from ALU

        if (reg_offset)
        begin
            bundle.read_c_sel              = instr[3:0];      // Rm
            bundle.ctrl.operand.imm_val    = reg_read_C_bus;
            bundle.ctrl.operand.barrel_op  = barrel_op_e'({1'b0, instr[6:5]});
            bundle.ctrl.operand.shift_val  = {27'd0, instr[11:7]};
        end
        else
        begin
            bundle.ctrl.operand.imm_val    = {20'd0, instr[11:0]};
            bundle.ctrl.operand.barrel_op  = BARREL_LSL;
            bundle.ctrl.operand.shift_val  = 32'd0;
        end

        if (pre_index)
        begin
            bundle.ctrl.operand.imm_out_en = 1'b1;            // offset on B bus
            bundle.ctrl.mem.data_out_sel   = DOUT_PASS_THROUGH;
            bundle.ctrl.wb.reg_write_en    = base_wb;
        end
        else
        begin
            // first cycle latches store data, base updated later
            bundle.ctrl.operand.read_b_en   = 1'b1;
            bundle.ctrl.mem.data_out_sel    = DOUT_LATCHED;
            bundle.ctrl.mem.data_out_reg_we = 1'b1;
            bundle.ctrl.wb.reg_write_en     = 1'b0;
        end
    end

endmodule

//--- sim/instruction_decoder_props.sv
`timescale 1ns/1ps

module instruction_decoder_props
    import arm_decode_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input decode_ctrl_t de_ctrl
);

    int unsigned fail_count = 0;

    reset_default: assert property (@(posedge clk) !arst_n |-> de_ctrl == DECODE_DEFAULT)
    else
    begin
        fail_count++;
        $error("de_ctrl left the default bundle during reset");
    end

    // a PC write must redirect fetch through the ALU result
    pc_write_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        de_ctrl.wb.pc_write_en |-> de_ctrl.mem.addr_update && de_ctrl.mem.addr_sel == ADDR_ALU)
    else
    begin
        fail_count++;
        $error("PC write without ALU address update");
    end

    store_no_flags: assert property (@(posedge clk) disable iff (!arst_n)
        de_ctrl.mem.mem_write_en |-> !de_ctrl.wb.cpsr_write_en)
    else
    begin
        fail_count++;
        $error("memory write together with CPSR write");
    end

endmodule

bind instruction_decoder instruction_decoder_props u_props
(
    .clk     (clk),
    .arst_n  (arst_n),
    .de_ctrl (de_ctrl)
);

//--- sim/instruction_decoder_tb.sv
`timescale 1ns/1ps

module instruction_decoder_tb;
    import arm_decode_pkg::*;

    typedef struct packed
    {
        logic [31:0]    instr;
        cpsr_t          flags;
        logic [31:0]    c_bus;
        decode_bundle_t exp;                // expected ctrl and C select
    } row_t;

    logic         clk;
    logic         arst_n;
    logic [31:0]  fd_instruction;
    logic [31:0]  reg_read_C_bus;
    cpsr_t        in_cpsr;
    reg_idx_t     reg_read_C_sel;
    decode_ctrl_t de_ctrl;

    row_t rows[$];
    int   errors;
    int   tests;
    int   failed_tests;
    logic row_bad;
    logic timed_out;

    instruction_decoder uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // even code tests the flag expression, odd code its inverse
    function automatic logic cond_ok(logic [3:0] code, cpsr_t f);
        logic base;
        case (code[3:1])
            3'd0: base = f.z;
            3'd1: base = f.c;
            3'd2: base = f.n;
            3'd3: base = f.v;
            3'd4: base = f.c && !f.z;
            3'd5: base = (f.n == f.v);
            3'd6: base = !f.z && (f.n == f.v);
            default: base = 1'b1;           // AL passes, 1111 inverts to never
        endcase
        return base ^ code[0];
    endfunction

    function automatic decode_bundle_t expect_decode(logic [31:0] raw, cpsr_t f,
                                                    logic [31:0] c_bus);
        decode_bundle_t e;
        logic [31:0]    i;
        logic [31:0]    word_ofs;
        logic           to_pc;
        i = cond_ok(raw[31:28], f) ? raw : INSTR_NOP;
        word_ofs = {{8{i[23]}}, i[23:0]};
        to_pc = (i[15:12] == REG_PC);
        e.ctrl = DECODE_DEFAULT;
        e.read_c_sel = REG_R0;
        if (i[27:26] == 2'b00)
        begin
            e.ctrl.regs = '{i[19:16], i[25] ? REG_R0 : i[3:0], i[15:12]};
            e.ctrl.operand.alu_op = alu_op_e'(i[24:21]);
            e.ctrl.operand.read_b_en = !i[25];
            e.ctrl.operand.imm_out_en = i[25];
            e.ctrl.wb = '{i[24:23] != 2'b10, to_pc, 1'b0, i[20]};  // 10xx only sets flags
            e.ctrl.mem.addr_update = to_pc;
            e.ctrl.mem.addr_sel = to_pc ? ADDR_ALU : ADDR_INC;
            if (i[25])
            begin
                e.ctrl.operand.imm_val = {24'd0, i[7:0]};
                e.ctrl.operand.shift_val = {27'd0, i[11:8], 1'b0};
            end
            else if (i[4])
            begin
                e.read_c_sel = i[11:8];
                e.ctrl.operand.shift_val = c_bus;
                e.ctrl.operand.barrel_op = barrel_op_e'({1'b0, i[6:5]});
            end
            else
            begin
                e.ctrl.operand.shift_val = {27'd0, i[11:7]};
                e.ctrl.operand.barrel_op = (i[11:7] == 5'd0) ? BARREL_RRX
                                                             : barrel_op_e'({1'b0, i[6:5]});
            end
        end
        else if (i[27:25] == 3'b101)
        begin
            e.ctrl.regs = '{REG_PC, REG_R0, REG_PC};
            e.ctrl.operand.alu_op = ALU_ADD;
            e.ctrl.operand.imm_val = (word_ofs << 2) + 32'd4;
            e.ctrl.operand.imm_out_en = 1'b1;
            e.ctrl.wb = '{1'b1, 1'b1, i[24], 1'b0};
            e.ctrl.mem.addr_update = 1'b1;
            e.ctrl.mem.addr_sel = ADDR_ALU;
        end
        else if (i[27:26] == 2'b01 && !(i[25] && i[4]) && !i[20])
        begin
            e.ctrl.regs = '{i[19:16], i[15:12], i[19:16]};
            e.ctrl.operand.alu_op = i[23] ? ALU_ADD : ALU_SUB;
            e.ctrl.operand.imm_val = i[25] ? c_bus : {20'd0, i[11:0]};
            e.ctrl.operand.shift_val = i[25] ? {27'd0, i[11:7]} : 32'd0;
            e.ctrl.operand.barrel_op = i[25] ? barrel_op_e'({1'b0, i[6:5]}) : BARREL_LSL;
            e.ctrl.operand.read_b_en = !i[24];
            e.ctrl.operand.imm_out_en = i[24];
            e.ctrl.wb.reg_write_en = i[24] && i[21];
            e.ctrl.mem = '{i[24] ? DOUT_PASS_THROUGH : DOUT_LATCHED, !i[24],
                           1'b1, 1'b1, ADDR_ALU};
            e.read_c_sel = i[25] ? i[3:0] : REG_R0;
        end
        return e;
    endfunction

    task automatic add_row(input logic [31:0] ins, input cpsr_t f, input logic [31:0] c_bus);
        rows.push_back(row_t'{ins, f, c_bus, expect_decode(ins, f, c_bus)});
    endtask

    task automatic build_table();
        logic [31:0] rv;
        for (int k = 0; k < 4; k++)
        begin
            rv = $urandom;                  // immediate shift
            add_row({4'hE, 3'b000, rv[3:0], rv[4], rv[11:8], rv[15:12], rv[20:16],
                     rv[22:21], 1'b0, rv[27:24]}, cpsr_t'(rv[31:28]), $urandom);
            rv = $urandom;                  // register shift
            add_row({4'hE, 3'b000, rv[3:0], rv[4], rv[11:8], rv[15:12], rv[19:16], 1'b0,
                     rv[22:21], 1'b1, rv[27:24]}, cpsr_t'(rv[31:28]), $urandom);
            rv = $urandom;                  // rotated immediate
            add_row({4'hE, 3'b001, rv[3:0], rv[4], rv[11:8], rv[15:12], rv[19:16],
                     rv[27:20]}, cpsr_t'(rv[31:28]), $urandom);
            rv = $urandom;
            add_row({4'hE, 3'b101, rv[24], rv[23:0]}, cpsr_t'(rv[28:25]), $urandom);
        end
        add_row(32'hE1A0F001, 4'h0, 32'h0);         // MOV PC, R1
        add_row(32'hE3510005, 4'h0, 32'h0);         // CMP R1, #5
        add_row(32'hE1100002, 4'h0, 32'h0);         // TST R0, R2
        add_row(32'hE1A01352, 4'h0, 32'h7);         // MOV R1, R2, ASR R3
        add_row(32'hEA000004, 4'h0, 32'h0);
        add_row(32'hEBFFFFFE, 4'h0, 32'h0);         // BL backwards
        add_row(32'hE5A12004, 4'h0, 32'h0);         // STR R2, [R1, #4]!
        add_row(32'hE4432008, 4'h0, 32'h0);         // STRB R2, [R3], #-8
        add_row(32'hE7810102, 4'h0, $urandom);      // STR R0, [R1, R2, LSL #2]
        add_row(32'hE6045163, 4'h0, $urandom);      // STR R5, [R4], -R3, ROR #2
        for (int c = 0; c < 16; c++)
        begin
            add_row({c[3:0], 28'h1A01002}, 4'b0101, 32'h0);
            add_row({c[3:0], 28'h1A01002}, 4'b1010, 32'h0);
            add_row({c[3:0], 28'h1A01002}, 4'b0000, 32'h0);
        end
        add_row(32'hE5912000, 4'h0, 32'h0);         // LDR, not decoded
        add_row(32'hE7F000F0, 4'h0, 32'h0);
        add_row(32'hEE000010, 4'h0, 32'h0);
        add_row(32'hE0812003, 4'h0, 32'h0);
    endtask

    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        $display("MISMATCH t=%0t %s expected=%s actual=%s", $time, name, exp_s, act_s);
        errors++;
        row_bad = 1'b1;
    endtask

    task automatic check_sel(input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            report_mismatch("reg_read_C_sel", $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_ctrl(input decode_ctrl_t exp, input decode_ctrl_t act);
        if (act.regs !== exp.regs)
            report_mismatch("de_ctrl.regs", $sformatf("%h", exp.regs),
                            $sformatf("%h", act.regs));
        if (act.operand !== exp.operand)
            report_mismatch("de_ctrl.operand", $sformatf("%h", exp.operand),
                            $sformatf("%h", act.operand));
        if (act.wb !== exp.wb)
            report_mismatch("de_ctrl.wb", $sformatf("%b", exp.wb), $sformatf("%b", act.wb));
        if (act.mem !== exp.mem)
            report_mismatch("de_ctrl.mem", $sformatf("%h", exp.mem), $sformatf("%h", act.mem));
    endtask

    task automatic end_test(input string name);
        $display("%s: %s", name, row_bad ? "fail" : "ok");
        tests++;
        if (row_bad)
            failed_tests++;
        row_bad = 1'b0;
    endtask

    // high phase first, then returns once the clock is low
    task automatic wait_fall();
        int ticks;
        ticks = 0;
        while (clk !== 1'b1 && ticks < 200)
        begin
            #0.1;
            ticks++;
        end
        while (clk !== 1'b0 && ticks < 200)
        begin
            #0.1;
            ticks++;
        end
        if (ticks >= 200)
        begin
            $display("timeout: no falling clock edge within 20 ns at t=%0t", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_all();
        for (int n = 0; n < 8; n++)
        begin
            wait_fall();
            if (timed_out)
                return;
            check_ctrl(DECODE_DEFAULT, de_ctrl);
            check_bit("de_ctrl.mem.mem_write_en", 1'b0, de_ctrl.mem.mem_write_en);
        end
        fd_instruction = 32'hE5912000;             // load keeps the defaults
        arst_n = 1'b1;
        wait_fall();
        if (timed_out)
            return;
        check_ctrl(DECODE_DEFAULT, de_ctrl);
        end_test("reset");
        foreach (rows[r])
        begin
            fd_instruction = rows[r].instr;
            in_cpsr = rows[r].flags;
            reg_read_C_bus = rows[r].c_bus;
            #1;
            check_sel(rows[r].exp.read_c_sel, reg_read_C_sel);
            wait_fall();
            if (timed_out)
                return;
            check_ctrl(rows[r].exp.ctrl, de_ctrl);
            end_test($sformatf("row %0d instr %h", r, rows[r].instr));
        end
    endtask

    initial
    begin
        void'($urandom(71817));
        errors = 0;
        tests = 0;
        failed_tests = 0;
        row_bad = 1'b0;
        timed_out = 1'b0;
        arst_n = 1'b1;
        fd_instruction = 32'hE5A12004;             // store must stay blocked by reset
        reg_read_C_bus = 32'h0;
        in_cpsr = '0;
        build_table();
        #1;
        arst_n = 1'b0;
        run_all();
        errors += uut.u_props.fail_count;
        $display("tests=%0d failed=%0d mismatches=%0d", tests, failed_tests, errors);
        if (errors == 0 && failed_tests == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- src.f
hw/arm_decode_pkg.sv
hw/cond_check.sv
hw/dp_decode.sv
hw/branch_decode.sv
hw/store_decode.sv
hw/decode_control.sv
hw/instruction_decoder.sv
sim/instruction_decoder_props.sv
sim/instruction_decoder_tb.sv
